// File: pio_macros.svh
`ifndef PIO_MACROS_SVH
`define PIO_MACROS_SVH

// Machine count and the shared program store
`define PIO_NUM_SM    2
`define PIO_MEM_DEPTH 32
`define PIO_PC_W      5    // Must address all of PIO_MEM_DEPTH

// GPIO bus, one bit per pin
`define PIO_GPIO_W    32

// Clock divider, integer part only
`define PIO_DIV_W     16

`endif

// File: pio_pkg.sv
package pio_pkg;

  // Loader command codes with 3 and 4 left unused
  typedef enum logic [3:0] {
    ACT_NONE    = 4'd0,
    ACT_INSTR   = 4'd1,  // Write one program word
    ACT_WRAP    = 4'd2,
    ACT_PINS    = 4'd5,  // SET pin group
    ACT_ENABLE  = 4'd6,
    ACT_DIVIDER = 4'd7
  } pio_action_e;

  // Only JMP and SET execute, the rest retire as one-step no-ops
  typedef enum logic [2:0] {
    OP_JMP       = 3'b000,
    OP_WAIT      = 3'b001,
    OP_IN        = 3'b010,
    OP_OUT       = 3'b011,
    OP_PUSH_PULL = 3'b100,
    OP_MOV       = 3'b101,
    OP_IRQ       = 3'b110,
    OP_SET       = 3'b111
  } pio_opcode_e;

  typedef enum logic [2:0] {
    SET_PINS    = 3'b000,
    SET_X       = 3'b001,
    SET_PINDIRS = 3'b100
  } pio_set_dest_e;

  typedef enum logic [2:0] {
    JMP_ALWAYS = 3'b000,
    JMP_X_DEC  = 3'b010   // Taken if X non-zero, X decremented either way
  } pio_jmp_cond_e;

  // 16-bit program word
  typedef struct packed {
    pio_opcode_e opcode;
    logic [4:0]  delay;      // Extra idle steps after execution
    logic [2:0]  dest_cond;  // SET destination or JMP condition
    logic [4:0]  data_addr;  // SET data or JMP target
  } pio_instr_t;

  // Config data word whose view is picked by the action code
  typedef union packed {
    struct packed {
      logic [18:0] rsvd;
      logic [4:0]  wrap_bottom;  // Bits 12:8
      logic [2:0]  rsvd_mid;
      logic [4:0]  wrap_top;     // Bits 4:0
    } wrap;
    struct packed {
      logic [23:0] rsvd;
      logic [2:0]  set_count;    // Bits 7:5
      logic [4:0]  set_base;     // Bits 4:0
    } pins;
    struct packed {
      logic [15:0] rsvd;
      logic [15:0] div_int;      // 0 behaves as 1
    } div;
  } pio_conf_u;

endpackage

// File: pio_ctrl.sv
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_ctrl (
  input  logic                  clk_25mhz,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  pio_pkg::pio_action_e  cmd_action,
  input  logic [1:0]            cmd_mindex,
  input  logic [`PIO_PC_W-1:0]  cmd_index,
  input  pio_pkg::pio_conf_u    cmd_data,
  input  logic [`PIO_PC_W-1:0]  pc0,
  input  logic [`PIO_PC_W-1:0]  pc1,
  output logic                  cmd_ready,
  output pio_pkg::pio_instr_t   instr0,
  output pio_pkg::pio_instr_t   instr1,
  output logic                  enable0,
  output logic [`PIO_PC_W-1:0]  wrap_top0,
  output logic [`PIO_PC_W-1:0]  wrap_bottom0,
  output logic [4:0]            set_base0,
  output logic [2:0]            set_count0,
  output logic [`PIO_DIV_W-1:0] clk_div0,
  output logic                  enable1,
  output logic [`PIO_PC_W-1:0]  wrap_top1,
  output logic [`PIO_PC_W-1:0]  wrap_bottom1,
  output logic [4:0]            set_base1,
  output logic [2:0]            set_count1,
  output logic [`PIO_DIV_W-1:0] clk_div1
);

  pio_pkg::pio_instr_t  mem [`PIO_MEM_DEPTH];  // Shared by both machines

  // Per-machine configuration
  logic                  enable_r      [`PIO_NUM_SM];
  logic [`PIO_PC_W-1:0]  wrap_top_r    [`PIO_NUM_SM];
  logic [`PIO_PC_W-1:0]  wrap_bottom_r [`PIO_NUM_SM];
  logic [4:0]            set_base_r    [`PIO_NUM_SM];
  logic [2:0]            set_count_r   [`PIO_NUM_SM];
  logic [`PIO_DIV_W-1:0] clk_div_r     [`PIO_NUM_SM];

  logic alive;          // Low for the reset cycles
  logic any_running;
  logic instr_blocked;
  logic accept;

  always_comb begin
    any_running = 1'b0;
    for (int m = 0; m < `PIO_NUM_SM; m++)
      any_running = any_running | enable_r[m];
  end

  // Program store only changes with every machine stopped
  assign instr_blocked = cmd_valid && (cmd_action == pio_pkg::ACT_INSTR) && any_running;
  assign cmd_ready     = alive && !instr_blocked;
  assign accept        = cmd_valid && cmd_ready;

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      alive <= 1'b0;
      for (int m = 0; m < `PIO_NUM_SM; m++) begin
        enable_r[m]      <= 1'b0;
        wrap_top_r[m]    <= '1;   // Full memory by default
        wrap_bottom_r[m] <= '0;
        set_base_r[m]    <= '0;
        set_count_r[m]   <= '0;   // Owns no pins
        clk_div_r[m]     <= `PIO_DIV_W'd1;
      end
    end else begin
      alive <= 1'b1;
      for (int m = 0; m < `PIO_NUM_SM; m++) begin
        if (accept && cmd_mindex == 2'(m)) begin  // Other indices ignored
          case (cmd_action)
            pio_pkg::ACT_WRAP: begin
              wrap_top_r[m]    <= cmd_data.wrap.wrap_top;
              wrap_bottom_r[m] <= cmd_data.wrap.wrap_bottom;
            end
            pio_pkg::ACT_PINS: begin
              set_base_r[m]  <= cmd_data.pins.set_base;
              set_count_r[m] <= cmd_data.pins.set_count;
            end
            pio_pkg::ACT_ENABLE:  enable_r[m]  <= cmd_data[0];  // Bit 0 runs/stops
            pio_pkg::ACT_DIVIDER: clk_div_r[m] <= cmd_data.div.div_int;
            default: ;  // NONE and INSTR leave config alone
          endcase
        end
      end
    end
  end

  // Instruction write, mindex unused here
  always_ff @(posedge clk_25mhz) begin
    if (accept && cmd_action == pio_pkg::ACT_INSTR)
      mem[cmd_index] <= pio_pkg::pio_instr_t'(cmd_data[15:0]);
  end

  // One combinational read port per machine
  assign instr0 = mem[pc0];
  assign instr1 = mem[pc1];

  assign enable0      = enable_r[0];
  assign wrap_top0    = wrap_top_r[0];
  assign wrap_bottom0 = wrap_bottom_r[0];
  assign set_base0    = set_base_r[0];
  assign set_count0   = set_count_r[0];
  assign clk_div0     = clk_div_r[0];

  assign enable1      = enable_r[1];
  assign wrap_top1    = wrap_top_r[1];
  assign wrap_bottom1 = wrap_bottom_r[1];
  assign set_base1    = set_base_r[1];
  assign set_count1   = set_count_r[1];
  assign clk_div1     = clk_div_r[1];

endmodule

// File: pio_machine.sv
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_machine (
  input  logic                   clk_25mhz,
  input  logic                   reset,
  input  logic                   enable,
  input  pio_pkg::pio_instr_t    instr,        // Word at pc
  input  logic [`PIO_PC_W-1:0]   wrap_top,
  input  logic [`PIO_PC_W-1:0]   wrap_bottom,
  input  logic [4:0]             set_base,
  input  logic [2:0]             set_count,
  input  logic [`PIO_DIV_W-1:0]  clk_div,
  output logic [`PIO_PC_W-1:0]   pc,
  output logic [`PIO_GPIO_W-1:0] pins,
  output logic [`PIO_GPIO_W-1:0] pindirs,
  output logic [`PIO_GPIO_W-1:0] owned         // SET pin group
);

  logic [`PIO_DIV_W-1:0]  div_cnt;      // Cycles left until next step
  logic [`PIO_DIV_W-1:0]  div_reload;
  logic [4:0]             delay_cnt;    // Idle steps left
  logic [31:0]            x;
  logic                   step;
  logic                   exec;
  logic                   jmp_taken;
  logic [`PIO_PC_W-1:0]   pc_seq;       // Next pc without a jump
  logic [`PIO_GPIO_W-1:0] group_low;    // Count ones, unrotated
  logic [`PIO_GPIO_W-1:0] set_value;    // SET data placed on the group

  // Left rotate, group may wrap past pin 31
  function automatic logic [`PIO_GPIO_W-1:0] rotl(
    input logic [`PIO_GPIO_W-1:0] v,
    input logic [4:0]             sh
  );
    logic [2*`PIO_GPIO_W-1:0] dbl;
    dbl  = {v, v} << sh;
    rotl = dbl[2*`PIO_GPIO_W-1:`PIO_GPIO_W];
  endfunction

  // Divisor 0 steps every cycle like 1
  assign div_reload = (clk_div == '0) ? '0 : clk_div - 1'b1;
  assign step       = enable && (div_cnt == '0);
  assign exec       = step && (delay_cnt == '0);  // Delay done, run the word

  assign pc_seq = (pc == wrap_top) ? wrap_bottom : pc + 1'b1;

  always_comb begin
    jmp_taken = 1'b0;
    if (instr.opcode == pio_pkg::OP_JMP) begin
      case (instr.dest_cond)
        pio_pkg::JMP_ALWAYS: jmp_taken = 1'b1;
        pio_pkg::JMP_X_DEC:  jmp_taken = (x != '0);  // Tested before decrement
        default:             jmp_taken = 1'b0;       // Unsupported, falls through
      endcase
    end
  end

  assign group_low = (`PIO_GPIO_W'(1) << set_count) - 1'b1;
  assign owned     = rotl(group_low, set_base);
  // Low count bits of data, bits past 4 read as zero
  assign set_value = rotl(`PIO_GPIO_W'(instr.data_addr) & group_low, set_base);

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      pc        <= '0;
      div_cnt   <= '0;
      delay_cnt <= '0;
      x         <= '0;
      pins      <= '0;
      pindirs   <= '0;
    end else if (!enable) begin
      // Parked at wrap_bottom, first step on the edge after enable
      pc        <= wrap_bottom;
      div_cnt   <= '0;
      delay_cnt <= '0;
    end else begin
      if (step)
        div_cnt <= div_reload;
      else
        div_cnt <= div_cnt - 1'b1;

      if (step && delay_cnt != '0)
        delay_cnt <= delay_cnt - 1'b1;  // Idle step

      if (exec) begin
        delay_cnt <= instr.delay;
        pc        <= jmp_taken ? instr.data_addr : pc_seq;
        case (instr.opcode)
          pio_pkg::OP_JMP: begin
            if (instr.dest_cond == pio_pkg::JMP_X_DEC)
              x <= x - 1'b1;  // Wraps from 0 to all ones
          end
          pio_pkg::OP_SET: begin
            case (instr.dest_cond)
              pio_pkg::SET_PINS:    pins    <= (pins & ~owned) | set_value;
              pio_pkg::SET_PINDIRS: pindirs <= (pindirs & ~owned) | set_value;
              pio_pkg::SET_X:       x       <= 32'(instr.data_addr);
              default: ;
            endcase
          end
          default: ;  // No-op, one step
        endcase
      end
    end
  end

endmodule

// File: pio_pin_merge.sv
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_pin_merge (
  input  logic [`PIO_GPIO_W-1:0] pins0,
  input  logic [`PIO_GPIO_W-1:0] pindirs0,
  input  logic [`PIO_GPIO_W-1:0] owned0,
  input  logic [`PIO_GPIO_W-1:0] pins1,
  input  logic [`PIO_GPIO_W-1:0] pindirs1,
  input  logic [`PIO_GPIO_W-1:0] owned1,
  output logic [`PIO_GPIO_W-1:0] gpio_out,
  output logic [`PIO_GPIO_W-1:0] gpio_dir
);

  // Per pin priority: machine 1, then machine 0, else low
  always_comb begin
    for (int i = 0; i < `PIO_GPIO_W; i++) begin
      if (owned1[i]) begin
        gpio_out[i] = pins1[i];
        gpio_dir[i] = pindirs1[i];
      end else if (owned0[i]) begin
        gpio_out[i] = pins0[i];
        gpio_dir[i] = pindirs0[i];
      end else begin
        // Nobody drives this pin
        gpio_out[i] = 1'b0;
        gpio_dir[i] = 1'b0;
      end
    end
  end

endmodule

// File: pio_top.sv
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_top (
  input  logic                   clk_25mhz,
  input  logic                   reset,
  input  logic                   cmd_valid,
  input  pio_pkg::pio_action_e   cmd_action,
  input  logic [1:0]             cmd_mindex,
  input  logic [`PIO_PC_W-1:0]   cmd_index,
  input  pio_pkg::pio_conf_u     cmd_data,
  output logic                   cmd_ready,
  output logic [`PIO_GPIO_W-1:0] gpio_out,
  output logic [`PIO_GPIO_W-1:0] gpio_dir
);

  // Machine 0 side
  pio_pkg::pio_instr_t    instr0;
  logic [`PIO_PC_W-1:0]   pc0;
  logic                   enable0;
  logic [`PIO_PC_W-1:0]   wrap_top0;
  logic [`PIO_PC_W-1:0]   wrap_bottom0;
  logic [4:0]             set_base0;
  logic [2:0]             set_count0;
  logic [`PIO_DIV_W-1:0]  clk_div0;
  logic [`PIO_GPIO_W-1:0] pins0;
  logic [`PIO_GPIO_W-1:0] pindirs0;
  logic [`PIO_GPIO_W-1:0] owned0;

  // Machine 1 side
  pio_pkg::pio_instr_t    instr1;
  logic [`PIO_PC_W-1:0]   pc1;
  logic                   enable1;
  logic [`PIO_PC_W-1:0]   wrap_top1;
  logic [`PIO_PC_W-1:0]   wrap_bottom1;
  logic [4:0]             set_base1;
  logic [2:0]             set_count1;
  logic [`PIO_DIV_W-1:0]  clk_div1;
  logic [`PIO_GPIO_W-1:0] pins1;
  logic [`PIO_GPIO_W-1:0] pindirs1;
  logic [`PIO_GPIO_W-1:0] owned1;

  pio_ctrl ctrl (
    .clk_25mhz    (clk_25mhz),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_action   (cmd_action),
    .cmd_mindex   (cmd_mindex),
    .cmd_index    (cmd_index),
    .cmd_data     (cmd_data),
    .pc0          (pc0),
    .pc1          (pc1),
    .cmd_ready    (cmd_ready),
    .instr0       (instr0),
    .instr1       (instr1),
    .enable0      (enable0),
    .wrap_top0    (wrap_top0),
    .wrap_bottom0 (wrap_bottom0),
    .set_base0    (set_base0),
    .set_count0   (set_count0),
    .clk_div0     (clk_div0),
    .enable1      (enable1),
    .wrap_top1    (wrap_top1),
    .wrap_bottom1 (wrap_bottom1),
    .set_base1    (set_base1),
    .set_count1   (set_count1),
    .clk_div1     (clk_div1)
  );

  pio_machine sm0 (
    .clk_25mhz   (clk_25mhz),
    .reset       (reset),
    .enable      (enable0),
    .instr       (instr0),
    .wrap_top    (wrap_top0),
    .wrap_bottom (wrap_bottom0),
    .set_base    (set_base0),
    .set_count   (set_count0),
    .clk_div     (clk_div0),
    .pc          (pc0),
    .pins        (pins0),
    .pindirs     (pindirs0),
    .owned       (owned0)
  );

  pio_machine sm1 (
    .clk_25mhz   (clk_25mhz),
    .reset       (reset),
    .enable      (enable1),
    .instr       (instr1),
    .wrap_top    (wrap_top1),
    .wrap_bottom (wrap_bottom1),
    .set_base    (set_base1),
    .set_count   (set_count1),
    .clk_div     (clk_div1),
    .pc          (pc1),
    .pins        (pins1),
    .pindirs     (pindirs1),
    .owned       (owned1)
  );

  pio_pin_merge merge (
    .pins0    (pins0),
    .pindirs0 (pindirs0),
    .owned0   (owned0),
    .pins1    (pins1),
    .pindirs1 (pindirs1),
    .owned1   (owned1),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

endmodule

// File: pio_tb.sv
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_tb;

  localparam int MAX_RECS   = 64;
  localparam int CMD_CYCLES = 6;  // Max idle gap plus handshake

  logic                   clk_25mhz = 1'b0;
  logic                   reset;
  logic                   cmd_valid;
  pio_pkg::pio_action_e   cmd_action;
  logic [1:0]             cmd_mindex;
  logic [`PIO_PC_W-1:0]   cmd_index;
  pio_pkg::pio_conf_u     cmd_data;
  logic                   cmd_ready;
  logic [`PIO_GPIO_W-1:0] gpio_out;
  logic [`PIO_GPIO_W-1:0] gpio_dir;

  // Record: kind, test, action/measure, mindex, index/pin, window, expected, data
  logic [79:0] recs [MAX_RECS];
  string       test_names [16];
  integer      seed = 43;
  int          cycle_count = 0;
  int          cycle_limit = 0;  // Set once the data file is loaded
  logic [3:0]  cur_test = 4'h0;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;

  pio_top DUT (
    .clk_25mhz  (clk_25mhz),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_action (cmd_action),
    .cmd_mindex (cmd_mindex),
    .cmd_index  (cmd_index),
    .cmd_data   (cmd_data),
    .cmd_ready  (cmd_ready),
    .gpio_out   (gpio_out),
    .gpio_dir   (gpio_dir)
  );

  always #20 clk_25mhz = ~clk_25mhz;  // 25 MHz

  // Run limit
  always @(posedge clk_25mhz) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: no result after %0d cycles, a handshake or pin edge never came",
               cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [4:0] pin,
                             input int expected, input int actual);
    checks++;
    test_checks++;
    assert (actual == expected) else begin
      $display("error %s: %s on pin %0d, expected %0d, actual %0d",
               test_names[cur_test], what, pin, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    $display("test %s finished, %0d checks, %0d errors",
             test_names[cur_test], test_checks, test_errors);
  endtask

  // Valid held until ready seen at a falling edge
  task automatic send_cmd(input logic [79:0] r);
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(posedge clk_25mhz);  // Idle, valid low
    @(posedge clk_25mhz);
    cmd_valid  <= 1'b1;
    cmd_action <= pio_pkg::pio_action_e'(r[71:68]);
    cmd_mindex <= r[65:64];
    cmd_index  <= r[60:56];
    cmd_data   <= pio_pkg::pio_conf_u'(r[31:0]);
    do begin
      @(negedge clk_25mhz);
    end while (!cmd_ready);
    @(posedge clk_25mhz);  // Transfer edge
    cmd_valid <= 1'b0;
  endtask

  // Present a command for a window, count cycles with ready high, then withdraw it
  task automatic probe_ready(input logic [79:0] r, output int ready_cycles);
    @(posedge clk_25mhz);
    cmd_valid  <= 1'b1;
    cmd_action <= pio_pkg::pio_action_e'(r[71:68]);
    cmd_mindex <= r[65:64];
    cmd_index  <= r[60:56];
    cmd_data   <= pio_pkg::pio_conf_u'(r[31:0]);
    ready_cycles = 0;
    repeat (int'(r[55:48])) begin
      @(negedge clk_25mhz);
      if (cmd_ready)
        ready_cycles++;
    end
    @(posedge clk_25mhz);
    cmd_valid <= 1'b0;
  endtask

  // Called at a falling edge, returns cycles up to the next 0 to 1 change
  task automatic next_rise(input logic [4:0] pin, output int cycles);
    logic prev;
    logic cur;
    cycles = 0;
    cur = gpio_out[pin];
    do begin
      prev = cur;
      @(negedge clk_25mhz);
      cur = gpio_out[pin];
      cycles++;
    end while (!(cur && !prev));
  endtask

  task automatic count_rises(input logic [4:0] pin, input int window, output int rises);
    int   sync_cycles;
    logic prev;
    logic cur;
    next_rise(pin, sync_cycles);  // Align to the waveform
    rises = 0;
    cur = gpio_out[pin];
    repeat (window) begin
      prev = cur;
      @(negedge clk_25mhz);
      cur = gpio_out[pin];
      if (cur && !prev)
        rises++;
    end
  endtask

  task automatic run_check(input logic [79:0] r);
    logic [4:0] pin;
    int         expected;
    int         actual;
    int         skipped;
    string      what;
    pin      = r[60:56];
    expected = int'(r[47:32]);
    actual   = 0;
    @(negedge clk_25mhz);  // Outputs settled here
    case (r[71:68])
      4'h1: begin
        what = "period";
        next_rise(pin, skipped);  // Sync
        next_rise(pin, skipped);  // May span a config change
        next_rise(pin, actual);
      end
      4'h2: begin
        what = "rising edges";
        count_rises(pin, int'(r[55:48]), actual);
      end
      4'h3: begin
        what = "output level";
        actual = int'(gpio_out[pin]);
      end
      4'h4: begin
        what = "direction";
        actual = int'(gpio_dir[pin]);
      end
      default: begin
        what = "unknown measurement";
        actual = -1;
      end
    endcase
    check_value(what, pin, expected, actual);
  endtask

  initial begin
    int          i;
    int          cmds;
    int          windows;
    int          ready_cycles;
    logic [79:0] r;
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_action = pio_pkg::ACT_NONE;
    cmd_mindex = 2'd0;
    cmd_index  = '0;
    cmd_data   = '0;
    test_names[0] = "none";
    test_names[1] = "square_wave";
    test_names[2] = "divider_scaling";
    test_names[3] = "jmp_x_loop";
    test_names[4] = "two_machines";
    test_names[5] = "overlap_priority";
    test_names[6] = "back_pressure";
    for (i = 0; i < MAX_RECS; i++)
      recs[i] = '0;
    $readmemh("pio_testdata.txt", recs);

    // Limit from windows and command count
    cmds    = 0;
    windows = 0;
    for (i = 0; i < MAX_RECS; i++) begin
      if (recs[i][79:76] == 4'h1)
        cmds++;
      else if (recs[i][79:76] != 4'h0)
        windows += int'(recs[i][55:48]);
    end
    cycle_limit = 2 * (windows + cmds * CMD_CYCLES) + 3;

    repeat (3) @(posedge clk_25mhz);
    reset <= 1'b0;

    for (i = 0; i < MAX_RECS; i++) begin
      r = recs[i];
      if (r[79:76] == 4'h0)
        break;  // End of records
      if (r[75:72] != cur_test) begin
        if (cur_test != 4'h0)
          finish_test();
        cur_test    = r[75:72];
        test_checks = 0;
        test_errors = 0;
        tests++;
      end
      case (r[79:76])
        4'h1: send_cmd(r);
        4'h2: run_check(r);
        4'h3: begin
          probe_ready(r, ready_cycles);
          check_value("cycles with ready high", r[60:56], int'(r[47:32]), ready_cycles);
        end
        default: begin
          $display("record %0d has a kind the testbench does not know", i);
          errors++;
        end
      endcase
    end
    if (cur_test != 4'h0)
      finish_test();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: pio_testdata.txt
// kind_test_sel_mindex_index/pin_window_expected_data, kind 1 cmd, 2 check, 3 ready probe
// sel is the action for kind 1 and 3, else 1 period, 2 rising edges, 3 out level, 4 dir
1_1_1_0_00_00_0000_0000E081
1_1_1_0_01_00_0000_0000E101
1_1_1_0_02_00_0000_0000E000
1_1_1_0_03_00_0000_00000001
1_1_2_0_00_00_0000_00000003
1_1_5_0_00_00_0000_00000020
1_1_7_0_00_00_0000_00000001
1_1_6_0_00_00_0000_00000001
2_1_1_0_00_18_0004_00000000
2_1_4_0_00_02_0001_00000000
1_2_7_0_00_00_0000_00000003
2_2_1_0_00_30_000C_00000000
1_2_7_0_00_00_0000_00000000
2_2_1_0_00_18_0004_00000000
1_3_6_0_00_00_0000_00000000
1_3_1_0_08_00_0000_0000E081
1_3_1_0_09_00_0000_0000E024
1_3_1_0_0A_00_0000_0000E001
1_3_1_0_0B_00_0000_0000E000
1_3_1_0_0C_00_0000_0000004A
1_3_1_0_0D_00_0000_0000A700
1_3_2_0_00_00_0000_0000080D
1_3_7_0_00_00_0000_00000001
1_3_6_0_00_00_0000_00000001
2_3_2_0_00_19_0005_00000000
1_4_2_1_00_00_0000_00000003
1_4_5_1_00_00_0000_00000024
1_4_7_1_00_00_0000_00000002
1_4_6_1_00_00_0000_00000001
2_4_1_0_04_28_0008_00000000
2_4_4_0_04_02_0001_00000000
2_4_2_0_00_19_0005_00000000
1_5_5_1_00_00_0000_00000020
2_5_1_0_00_28_0008_00000000
2_5_4_0_00_02_0000_00000000
2_5_3_0_04_02_0000_00000000
2_5_4_0_04_02_0000_00000000
3_6_1_0_01_04_0000_0000E301
1_6_6_0_00_00_0000_00000000
1_6_6_1_00_00_0000_00000000
1_6_5_1_00_00_0000_00000000
1_6_1_0_01_00_0000_0000E301
1_6_2_0_00_00_0000_00000003
1_6_6_0_00_00_0000_00000001
2_6_1_0_00_1E_0006_00000000

// File: list.f
+incdir+.
pio_pkg.sv
pio_ctrl.sv
pio_machine.sv
pio_pin_merge.sv
pio_top.sv
pio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, verdict taken from the simulation log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module pio_tb -f list.f -o pio_sim \
  > build.log 2>&1 &&
./obj_dir/pio_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qx "TB PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
